//--- src.f
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/pc_ctrl.sv
hdl/bpu_tables.sv
hdl/instr_admin.sv
hdl/instr_buffer.sv
hdl/frontend_top.sv
sim/tb_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_frontend -f src.f -o tb_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
    import isa_pkg::*;
    import fetch_pkg::*;

    typedef struct {
        string       name;
        logic [31:0] start_pc;  // Delivered by redirect
        logic [31:0] xfer_pc;   // Slot that gets the special opcode and the training
        logic [6:0]  xfer_op;
        int          n_taken;   // Taken updates first
        int          n_not;     // Then not-taken ones
        logic [31:0] target;
        int          pop_pct;   // Chance of a pop per cycle
        int          n_check;   // Entries compared
    } row_t;

    logic        clk;
    logic        arst_n;
    logic [31:0] fetch_pc;
    logic        fetch_line_valid;
    fetch_line_t fetch_line;
    logic        redirect;
    logic [31:0] redirect_pc;
    bpu_update_t upd;
    logic        ib_pop;
    logic        ib_valid;
    ib_entry_t   ib_entry;

    logic [31:0] prog [64];       // 256-byte image that aliases like the tables
    logic [1:0]  ref_cnt [16][4]; // Reference predictor state
    logic [31:0] ref_tgt [16][4];
    ib_entry_t   exp_q [$];
    row_t        rows [7];
    logic [31:0] rng;

    frontend_top u_frontend_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction memory answers the fetch PC at once
    always_comb begin
        fetch_line.pc = fetch_pc;
        for (int s = 0; s < 4; s++)
            fetch_line.instr[s] = prog[{fetch_pc[7:4], 2'(s)}];
    end

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {a[31:7] ^ a[24:0], 7'b0010011}; // OP-IMM opcode is never a transfer
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // JAL, JALR or BRANCH major opcode
    function automatic logic is_xfer(logic [31:0] w);
        return (w[6:0] == 7'h6f) || (w[6:0] == 7'h67) || (w[6:0] == 7'h63);
    endfunction

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_entry(string name, ib_entry_t exp, ib_entry_t act);
        if (act !== exp)
            stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                      name, exp, act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
            stop_with_error($sformatf("CHECK FAILED %s expected %b actual %b",
                                      name, exp, act));
    endtask

    task automatic check_pc(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        if (act !== exp)
            stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                      name, exp, act));
    endtask

    // Walk the program line by line and queue what decode should see
    task automatic build_expected(logic [31:0] pc, int n);
        ib_entry_t   e;
        logic [31:0] base;
        logic [3:0]  idx;
        logic        taken;
        exp_q.delete();
        while (exp_q.size() < n) begin
            base  = pc & ~32'hf;
            idx   = pc[7:4];
            taken = 1'b0;
            for (int s = int'(pc[3:2]); s < 4 && !taken; s++) begin // Skip slots before PC
                e.instr       = prog[{idx, 2'(s)}];
                e.pc          = base + 32'(4 * s);
                taken         = is_xfer(e.instr) && ref_cnt[idx][s][1];
                e.pred_taken  = taken;
                e.pred_target = taken ? ref_tgt[idx][s] : 32'h0;
                exp_q.push_back(e);
            end
            pc = taken ? e.pred_target : base + 32'd16; // Trim after the first taken
        end
    endtask

    // One backend strobe mirrored into the reference counters
    task automatic train(logic [31:0] pc, logic taken, logic [31:0] target);
        logic [3:0] idx;
        logic [1:0] s;
        idx = pc[7:4];
        s   = pc[3:2];
        upd = '{en: 1'b1, pc: pc, taken: taken, target: target};
        @(posedge clk);
        #1;
        upd.en = 1'b0;
        if (taken) begin
            ref_tgt[idx][s] = target;
            if (ref_cnt[idx][s] != 2'd3)
                ref_cnt[idx][s] = ref_cnt[idx][s] + 2'd1;
        end else if (ref_cnt[idx][s] != 2'd0) begin
            ref_cnt[idx][s] = ref_cnt[idx][s] - 2'd1; // Saturates at 0
        end
    endtask

    task automatic redirect_to(logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        ib_pop      = 1'b0;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        check_pc("fetch_pc_after_redirect", pc, fetch_pc); // Loaded at the redirect edge
        check_bit("ib_valid_after_redirect", 1'b0, ib_valid); // Queue emptied
    endtask

    // Pop each entry after a random gap
    task automatic pop_and_check(string name, int pct, int n);
        int wait_cycles;
        for (int k = 0; k < n; k++) begin
            wait_cycles = 0;
            rng         = xorshift(rng);
            while (!(ib_valid && (rng % 100) < pct)) begin
                if (wait_cycles == 200)
                    stop_with_error($sformatf("Timeout waiting for entry %0d of %s", k, name));
                ib_pop = 1'b0;
                @(posedge clk);
                #1;
                rng         = xorshift(rng);
                wait_cycles = wait_cycles + 1;
            end
            check_entry($sformatf("%s[%0d]", name, k), exp_q[k], ib_entry);
            ib_pop = 1'b1; // Head leaves at the next edge
            @(posedge clk);
            #1;
        end
        ib_pop = 1'b0;
    endtask

    initial begin
        logic [31:0] w_fill;
        rng              = 32'ha09a;
        arst_n           = 1'b0;
        fetch_line_valid = 1'b0; // No line during reset
        redirect         = 1'b0;
        redirect_pc      = 32'h0;
        upd              = '0;
        ib_pop           = 1'b0;
        for (int l = 0; l < 16; l++) begin
            for (int s = 0; s < 4; s++) begin
                ref_cnt[l][s] = 2'b01; // Weakly not taken
                ref_tgt[l][s] = 32'h0;
            end
        end
        for (int w = 0; w < 64; w++)
            prog[w] = fill_word(32'(4 * w));
        rows[0] = '{"straight_line", 32'h20, 32'h0, 7'h13, 0, 0, 32'h0, 100, 12};
        rows[1] = '{"mid_line_start", 32'h48, 32'h0, 7'h13, 0, 0, 32'h0, 100, 8};
        rows[2] = '{"branch_taken", 32'h60, 32'h64, 7'h63, 2, 0, 32'ha4, 100, 10};
        rows[3] = '{"trained_non_branch", 32'h80, 32'h84, 7'h13, 2, 0, 32'hc0, 100, 10};
        rows[4] = '{"jal_saturate", 32'h10, 32'h18, 7'h6f, 1, 3, 32'h40, 100, 10};
        rows[5] = '{"jalr_taken", 32'he4, 32'hec, 7'h67, 2, 0, 32'h34, 70, 10};
        rows[6] = '{"branch_slow_pop", 32'h60, 32'h64, 7'h63, 0, 0, 32'ha4, 15, 12};
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (4) begin // Queue stays empty without a line
            @(posedge clk);
            #1;
            check_bit("ib_valid_after_reset", 1'b0, ib_valid);
            check_pc("fetch_pc_after_reset", 32'h0, fetch_pc); // PC holds at the reset address
        end
        fetch_line_valid = 1'b1;
        foreach (rows[r]) begin
            for (int w = 0; w < 64; w++)
                prog[w] = fill_word(32'(4 * w));
            w_fill                   = fill_word(rows[r].xfer_pc);
            prog[rows[r].xfer_pc[7:2]] = {w_fill[31:7], rows[r].xfer_op};
            repeat (rows[r].n_taken) train(rows[r].xfer_pc, 1'b1, rows[r].target);
            repeat (rows[r].n_not) train(rows[r].xfer_pc, 1'b0, rows[r].target);
            build_expected(rows[r].start_pc, rows[r].n_check);
            redirect_to(rows[r].start_pc); // Also drops what the last row left queued
            pop_and_check(rows[r].name, rows[r].pop_pct, rows[r].n_check);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- hdl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                     clk,
    input  logic                     arst_n,
    output logic [isa_pkg::xlen-1:0] fetch_pc,         // To instruction memory
    input  logic                     fetch_line_valid,
    input  fetch_pkg::fetch_line_t   fetch_line,
    input  logic                     redirect,         // Backend strobe
    input  logic [isa_pkg::xlen-1:0] redirect_pc,
    input  fetch_pkg::bpu_update_t   upd,
    input  logic                     ib_pop,
    output logic                     ib_valid,
    output fetch_pkg::ib_entry_t     ib_entry
);
    import isa_pkg::*;
    import fetch_pkg::*;

    bpu_pred_t       pred;
    admin_out_t      admin_out;
    logic            pred_taken;
    logic [xlen-1:0] pred_target;
    logic            space_ok;
    logic            accept;

    // Line enters the queue only with room and no redirect
    assign accept = fetch_line_valid && space_ok && !redirect;

    pc_ctrl u_pc_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .accept      (accept),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .fetch_pc    (fetch_pc)
    );

    bpu_tables u_bpu_tables (
        .clk      (clk),
        .arst_n   (arst_n),
        .fetch_pc (fetch_pc),
        .pred     (pred),
        .upd      (upd)
    );

    instr_admin u_instr_admin (
        .line        (fetch_line),
        .pred        (pred),
        .admin_out   (admin_out),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    instr_buffer u_instr_buffer (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (redirect),
        .wr_en      (accept),
        .wr_data    (admin_out),
        .space_ok   (space_ok),
        .pop        (ib_pop),
        .head       (ib_entry),
        .head_valid (ib_valid)
    );

endmodule

//--- hdl/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,     // Redirect empties the queue
    input  logic                  wr_en,
    input  fetch_pkg::admin_out_t wr_data,
    output logic                  space_ok,  // Room for a full line
    input  logic                  pop,
    output fetch_pkg::ib_entry_t  head,
    output logic                  head_valid
);
    import isa_pkg::*;
    import fetch_pkg::*;

    ib_entry_t mem [ib_depth];

    logic [ib_ptr_bits-1:0] wr_ptr;
    logic [ib_ptr_bits-1:0] rd_ptr;
    logic [ib_cnt_bits-1:0] count;

    logic [fetch_width-1:0][slot_bits:0] slot_pos; // Packed position of each valid slot
    logic [slot_bits:0]                  wr_cnt;   // Valid slots in this line
    logic [slot_bits:0]                  wr_num;   // Slots actually written
    logic                                pop_ok;
    ib_entry_t                           slot_entry [fetch_width];

    // Running count of valid slots gives each one its place
    always_comb begin
        wr_cnt = '0;
        for (int i = 0; i < fetch_width; i++) begin
            slot_pos[i] = wr_cnt;
            wr_cnt      = wr_cnt + (slot_bits + 1)'(wr_data.valid[i]);
            slot_entry[i].instr       = wr_data.instr[i];
            slot_entry[i].pc          = wr_data.pc + xlen'(4 * i); // Line PC carries the offset
            slot_entry[i].pred_taken  = wr_data.taken[i];
            slot_entry[i].pred_target = wr_data.target[i];
        end
    end

    assign wr_num     = wr_en ? wr_cnt : '0;
    assign pop_ok     = pop && (count != '0); // Empty pop is ignored
    assign space_ok   = (ib_cnt_bits'(ib_depth) - count) >= ib_cnt_bits'(fetch_width);
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // Valid slots land at consecutive entries
    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            for (int i = 0; i < fetch_width; i++) begin
                if (wr_data.valid[i])
                    mem[wr_ptr + ib_ptr_bits'(slot_pos[i])] <= slot_entry[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + ib_ptr_bits'(wr_num); // Wraps at depth
            rd_ptr <= rd_ptr + ib_ptr_bits'(pop_ok);
            count  <= count + ib_cnt_bits'(wr_num) - ib_cnt_bits'(pop_ok);
        end
    end

endmodule

//--- hdl/instr_admin.sv
`timescale 1ns/1ps

module instr_admin (
    input  fetch_pkg::fetch_line_t   line,
    input  fetch_pkg::bpu_pred_t     pred,
    output fetch_pkg::admin_out_t    admin_out,
    output logic                     pred_taken,  // Some kept prediction says taken
    output logic [isa_pkg::xlen-1:0] pred_target  // Target of the first one
);
    import isa_pkg::*;
    import fetch_pkg::*;

    logic [slot_bits-1:0] offset; // Slot of the fetch PC within the line

    logic [fetch_width-1:0][xlen-1:0] al_instr;
    logic [fetch_width-1:0][1:0]      al_cnt;
    logic [fetch_width-1:0][xlen-1:0] al_tgt;
    logic [fetch_width-1:0]           al_valid;

    xfer_e                  xfer [fetch_width];
    logic [fetch_width-1:0] kept_taken; // Taken prediction on a real transfer
    logic [fetch_width-1:0] trim_mask;  // Slots up to the first kept taken

    assign offset = line.pc[2 +: slot_bits];

    // Drop the slots in front of the PC and move the rest down to slot 0
    // Counters and targets travel with their instruction
    always_comb begin
        int src;
        for (int i = 0; i < fetch_width; i++) begin
            src         = i + int'(offset);
            al_instr[i] = '0;
            al_cnt[i]   = '0;
            al_tgt[i]   = '0;
            al_valid[i] = 1'b0;
            if (src < fetch_width) begin
                al_instr[i] = line.instr[src];
                al_cnt[i]   = pred.cnt[src];
                al_tgt[i]   = pred.target[src];
                al_valid[i] = 1'b1;
            end
        end
    end

    // Classify each slot by major opcode
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            case (opcode_e'(al_instr[i][6:0]))
                OP_JAL:    xfer[i] = XFER_JAL;
                OP_JALR:   xfer[i] = XFER_JALR;
                OP_BRANCH: xfer[i] = XFER_BRANCH;
                default:   xfer[i] = XFER_OTHER;
            endcase
            // Counter MSB means taken
            kept_taken[i] = al_valid[i] && (xfer[i] != XFER_OTHER) && al_cnt[i][1];
        end
    end

    // First kept taken slot wins, later slots are cut
    always_comb begin
        logic found;
        found       = 1'b0;
        pred_target = '0;
        for (int i = 0; i < fetch_width; i++) begin
            trim_mask[i] = !found;
            if (!found && kept_taken[i]) begin
                found       = 1'b1;
                pred_target = al_tgt[i];
            end
        end
        pred_taken = found;
    end

    always_comb begin
        admin_out.valid = al_valid & trim_mask;
        admin_out.taken = kept_taken & admin_out.valid; // Only the first survives
        admin_out.pc    = line.pc;
        for (int i = 0; i < fetch_width; i++) begin
            admin_out.instr[i]  = admin_out.valid[i] ? al_instr[i] : '0;
            admin_out.target[i] = admin_out.taken[i] ? al_tgt[i] : '0;
        end
    end

endmodule

//--- hdl/bpu_tables.sv
`timescale 1ns/1ps

module bpu_tables (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [isa_pkg::xlen-1:0] fetch_pc,
    output fetch_pkg::bpu_pred_t     pred,
    input  fetch_pkg::bpu_update_t   upd
);
    import isa_pkg::*;
    import fetch_pkg::*;

    logic [1:0]      cnt_q [bpu_lines][fetch_width]; // 2-bit saturating counters
    logic [xlen-1:0] tgt_q [bpu_lines][fetch_width]; // Branch targets

    logic [bpu_index_bits-1:0] rd_idx;
    logic [bpu_index_bits-1:0] upd_idx;
    logic [slot_bits-1:0]      upd_slot;

    // Index from the bits just above the line offset
    assign rd_idx   = fetch_pc[line_off_bits +: bpu_index_bits];
    assign upd_idx  = upd.pc[line_off_bits +: bpu_index_bits];
    assign upd_slot = upd.pc[2 +: slot_bits]; // Word within the line

    // Combinational read of the whole line
    always_comb begin
        for (int s = 0; s < fetch_width; s++) begin
            pred.cnt[s]    = cnt_q[rd_idx][s];
            pred.target[s] = tgt_q[rd_idx][s];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int l = 0; l < bpu_lines; l++) begin
                for (int s = 0; s < fetch_width; s++) begin
                    cnt_q[l][s] <= 2'b01; // Weakly not taken
                    tgt_q[l][s] <= '0;
                end
            end
        end else if (upd.en) begin
            if (upd.taken) begin
                tgt_q[upd_idx][upd_slot] <= upd.target;
                if (cnt_q[upd_idx][upd_slot] != 2'b11)
                    cnt_q[upd_idx][upd_slot] <= cnt_q[upd_idx][upd_slot] + 2'd1;
            end else if (cnt_q[upd_idx][upd_slot] != 2'b00) begin
                cnt_q[upd_idx][upd_slot] <= cnt_q[upd_idx][upd_slot] - 2'd1; // Step down
            end
        end
    end

endmodule

//--- hdl/pc_ctrl.sv
`timescale 1ns/1ps

module pc_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     accept,      // Line taken into the queue this cycle
    input  logic                     redirect,
    input  logic [isa_pkg::xlen-1:0] redirect_pc,
    input  logic                     pred_taken,
    input  logic [isa_pkg::xlen-1:0] pred_target,
    output logic [isa_pkg::xlen-1:0] fetch_pc
);
    import isa_pkg::*;
    import fetch_pkg::*;

    logic [xlen-1:0] line_base; // Fetch PC with the line offset cleared
    logic [xlen-1:0] next_line;
    logic [xlen-1:0] pc_next;

    assign line_base = fetch_pc & ~xlen'(line_bytes - 1);
    assign next_line = line_base + xlen'(line_bytes);

    // Redirect beats prediction beats sequential
    always_comb begin
        pc_next = fetch_pc; // Hold under back-pressure
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (accept && pred_taken) begin
            pc_next = pred_target;
        end else if (accept) begin
            pc_next = next_line;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= reset_pc;
        end else begin
            fetch_pc <= pc_next;
        end
    end

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    localparam int fetch_width    = 4;  // Instructions per line
    localparam int line_bytes     = 16;
    localparam int line_off_bits  = $clog2(line_bytes);
    localparam int slot_bits      = $clog2(fetch_width);
    localparam int bpu_index_bits = 4;  // 16 lines of prediction entries
    localparam int bpu_lines      = 1 << bpu_index_bits;
    localparam int ib_depth       = 16; // Queue slots
    localparam int ib_ptr_bits    = $clog2(ib_depth);
    localparam int ib_cnt_bits    = ib_ptr_bits + 1; // Room for a full count

    localparam logic [isa_pkg::xlen-1:0] reset_pc = 32'h0000_0000;

    // One line from instruction memory, pc is the fetch PC
    typedef struct packed {
        logic [fetch_width-1:0][isa_pkg::xlen-1:0] instr;
        logic [isa_pkg::xlen-1:0]                  pc;
    } fetch_line_t;

    // Counters and targets of one line, slot order
    typedef struct packed {
        logic [fetch_width-1:0][1:0]               cnt;
        logic [fetch_width-1:0][isa_pkg::xlen-1:0] target;
    } bpu_pred_t;

    // Aligned and trimmed line, slot 0 holds the instruction at pc
    typedef struct packed {
        logic [fetch_width-1:0][isa_pkg::xlen-1:0] instr;
        logic [fetch_width-1:0]                    valid;
        logic [fetch_width-1:0]                    taken;
        logic [fetch_width-1:0][isa_pkg::xlen-1:0] target;
        logic [isa_pkg::xlen-1:0]                  pc;
    } admin_out_t;

    // One queued instruction
    typedef struct packed {
        logic [isa_pkg::xlen-1:0] instr;
        logic [isa_pkg::xlen-1:0] pc;
        logic                     pred_taken;
        logic [isa_pkg::xlen-1:0] pred_target;
    } ib_entry_t;

    // Training strobe from the backend
    typedef struct packed {
        logic                     en;
        logic [isa_pkg::xlen-1:0] pc;
        logic                     taken;
        logic [isa_pkg::xlen-1:0] target;
    } bpu_update_t;

endpackage

//--- hdl/isa_pkg.sv
package isa_pkg;

    // Instruction and address width
    localparam int xlen = 32;

    // Major opcodes of the control-transfer instructions, bits [6:0]
    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011 // Conditional branches
    } opcode_e;

    // Control-transfer class of one fetch slot
    typedef enum logic [1:0] {
        XFER_OTHER  = 2'b00, // Anything that does not redirect flow
        XFER_JAL    = 2'b01,
        XFER_JALR   = 2'b10,
        XFER_BRANCH = 2'b11
    } xfer_e;

endpackage
